// File: hdl/vision_pkg.sv
package vision_pkg;

	// ----------------------------------------
	// memory and bus widths
	// ----------------------------------------
	localparam int ADDR_W      = 16;         // top bit selects the bank
	localparam int HOST_ADDR_W = ADDR_W - 1; // word address inside one bank
	localparam int WORD_W      = 16;
	localparam int BYTE_W      = 8;

	// byte phase inside one stored pixel group
	localparam int PHASE_W     = 3;
	localparam int GROUP_BYTES = 1 << PHASE_W; // 8 bytes per stored pixel

	localparam logic [PHASE_W-1:0] PH_CB = 3'd0; // 4:2:2 order cb y cr y
	localparam logic [PHASE_W-1:0] PH_Y  = 3'd1;
	localparam logic [PHASE_W-1:0] PH_CR = 3'd2;

	// ----------------------------------------
	// bt.601 constants, 8 fraction bits
	// ----------------------------------------
	localparam int K_W = 10;
	localparam logic [K_W-1:0] K_Y    = 10'd298; // 1.164
	localparam logic [K_W-1:0] K_CR_R = 10'd408; // 1.596
	localparam logic [K_W-1:0] K_CR_G = 10'd208; // 0.813
	localparam logic [K_W-1:0] K_CB_G = 10'd100; // 0.392
	localparam logic [K_W-1:0] K_CB_B = 10'd516; // 2.017

	// offsets at the x4 input scale
	localparam int SCALED_W = BYTE_W + 2;
	localparam logic [SCALED_W-1:0] Y_OFFSET = 10'd64;  // black level
	localparam logic [SCALED_W-1:0] C_OFFSET = 10'd512; // chroma zero

	localparam int PROD_W = 21; // signed products and sums

	// rgb565 field widths
	localparam int RB_W = 5;
	localparam int G_W  = 6;

	// frame port arbiter
	typedef enum logic [1:0] {
		ARB_IDLE,  // port free, host address on the ram
		ARB_WRITE, // capture word goes to memory
		ARB_READ,  // ram data for the host comes back
		ARB_HOLD   // host data latched, wait released
	} arb_state_t;

endpackage

// File: hdl/field_sync.sv
`timescale 1ns/1ps

module field_sync (
	input  logic                           clk_llc,
	input  logic                           resetx,
	input  logic                           vref,
	input  logic                           href,
	input  logic                           odd,
	output logic                           keep_byte,
	output logic [vision_pkg::PHASE_W-1:0] phase,
	input  logic                           pix_valid,
	output logic [vision_pkg::ADDR_W-1:0]  pix_addr,
	output logic                           read_bank,
	output logic                           irq0,
	output logic                           irq1
);
	import vision_pkg::*;

	logic                   odd_field;   // odd field active
	logic [2:0]             field_sr;    // odd_field delay line
	logic                   field_start;
	logic                   field_done;
	logic                   href_d1;
	logic                   href_rise;
	logic                   line_par;
	logic                   par_base;
	logic                   line_kept;
	logic                   bank;        // bank being written
	logic [HOST_ADDR_W-1:0] pix_cnt;

	assign odd_field   = odd & vref; // even fields ignored
	assign field_start = odd_field & ~field_sr[0];
	assign href_rise   = href & ~href_d1;

	// line parity, first line of a field kept
	// the toggle is seen in the first byte cycle of the line already
	assign par_base  = field_start ? 1'b0 : line_par;
	assign line_kept = par_base ^ href_rise;
	assign keep_byte = odd_field & href & line_kept;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			field_sr <= '0;
			href_d1  <= 1'b0;
			line_par <= 1'b0;
		end
		else
		begin
			field_sr <= {field_sr[1:0], odd_field};
			href_d1  <= href;
			line_par <= line_kept;
		end

	// byte phase, 0 outside kept lines
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			phase <= '0;
		else if (keep_byte)
			phase <= phase + PHASE_W'(1); // wraps every group
		else
			phase <= '0;

	// ----------------------------------------
	// bank and pixel address
	// ----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			bank <= 1'b1; // first field lands in bank 0
		else if (field_start)
			bank <= ~bank;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			pix_cnt <= '0;
		else if (field_start)
			pix_cnt <= '0;
		else if (pix_valid)
			pix_cnt <= pix_cnt + HOST_ADDR_W'(1); // next stored pixel

	assign pix_addr = {bank, pix_cnt};

	// host side sees the other bank while capturing, the last one between fields
	assign read_bank = field_sr[0] ? ~bank : bank;

	// two cycle pulse after the field falls
	assign field_done = ~field_sr[0] & field_sr[2];
	assign irq0       = field_done & ~bank; // bank 0 complete
	assign irq1       = field_done & bank;  // bank 1 complete

endmodule

// File: hdl/ycbcr_to_gray.sv
`timescale 1ns/1ps

module ycbcr_to_gray (
	input  logic                          clk_llc,
	input  logic                          resetx,
	input  logic [vision_pkg::BYTE_W-1:0] vpo,
	input  logic                          keep_byte,
	input  logic [vision_pkg::PHASE_W-1:0] phase,
	output logic                          pix_valid,
	output logic [vision_pkg::WORD_W-1:0] pix_word
);
	import vision_pkg::*;

	logic [BYTE_W-1:0]        cb_q;
	logic [BYTE_W-1:0]        y_q;
	logic [BYTE_W-1:0]        cr_q;
	logic [2:0]               vld_sr;          // latch, product, sum stages
	logic signed [PROD_W-1:0] y_w, cb_w, cr_w; // offset removed, x4 scale
	logic signed [PROD_W-1:0] x_p, a_p, b1_p, b2_p, c_p;
	logic signed [PROD_W-1:0] r_s, g_s, b_s;
	logic [G_W-1:0]           r6, g6, b6;
	logic [RB_W-1:0]          gray;

	// range check on a sum, returns bits 17..12
	function automatic logic [G_W-1:0] clip_sum(input logic signed [PROD_W-1:0] s);
		if (s[PROD_W-1])
			return '0; // negative
		else if (|s[PROD_W-2:PROD_W-3])
			return '1; // over full scale
		else
			return s[PROD_W-4 -: G_W];
	endfunction

	// ----------------------------------------
	// byte capture
	// ----------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (keep_byte && phase == PH_CB)
			cb_q <= vpo;
		if (keep_byte && phase == PH_Y)
			y_q <= vpo; // first luma of the pair
		if (keep_byte && phase == PH_CR)
			cr_q <= vpo;
	end

	// strobe follows the cr byte down the pipe
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[1:0], keep_byte && phase == PH_CR};

	assign y_w  = $signed(PROD_W'({y_q, 2'b00})) - $signed(PROD_W'(Y_OFFSET));
	assign cb_w = $signed(PROD_W'({cb_q, 2'b00})) - $signed(PROD_W'(C_OFFSET));
	assign cr_w = $signed(PROD_W'({cr_q, 2'b00})) - $signed(PROD_W'(C_OFFSET));

	// ----------------------------------------
	// products, then sums
	// ----------------------------------------
	always_ff @(posedge clk_llc)
	begin
		x_p  <= y_w * $signed(PROD_W'(K_Y));
		a_p  <= cr_w * $signed(PROD_W'(K_CR_R)); // r from cr
		b1_p <= cr_w * $signed(PROD_W'(K_CR_G)); // g from cr
		b2_p <= cb_w * $signed(PROD_W'(K_CB_G)); // g from cb
		c_p  <= cb_w * $signed(PROD_W'(K_CB_B)); // b from cb
	end

	always_ff @(posedge clk_llc)
	begin
		r_s <= x_p + a_p;
		g_s <= x_p - b1_p - b2_p;
		b_s <= x_p + c_p;
	end

	// r and b keep the upper five of the six clipped bits
	assign r6 = clip_sum(r_s);
	assign g6 = clip_sum(g_s);
	assign b6 = clip_sum(b_s);

	// r/4 + g/4 + b/8
	assign gray = RB_W'(r6[G_W-1:3]) + RB_W'(g6[G_W-1:2]) + RB_W'(b6[G_W-1:4]);

	assign pix_word  = {gray, gray, 1'b0, gray}; // gray as rgb565
	assign pix_valid = vld_sr[2];

endmodule

// File: hdl/frame_arbiter.sv
`timescale 1ns/1ps

module frame_arbiter (
	input  logic                               clk_llc,
	input  logic                               resetx,
	input  logic                               wr_req,
	input  logic [vision_pkg::ADDR_W-1:0]      wr_addr,
	input  logic [vision_pkg::WORD_W-1:0]      wr_data,
	input  logic                               read_bank,
	input  logic                               csx,
	input  logic                               rdx,
	input  logic [vision_pkg::HOST_ADDR_W-1:0] adr,
	output logic [vision_pkg::WORD_W-1:0]      data,
	output logic                               waitx,
	output logic [vision_pkg::ADDR_W-1:0]      ram_addr,
	output logic [vision_pkg::WORD_W-1:0]      ram_wdata,
	output logic                               ram_we,
	input  logic [vision_pkg::WORD_W-1:0]      ram_rdata
);
	import vision_pkg::*;

	arb_state_t        state;
	arb_state_t        state_nx;
	logic              pend_valid; // one write slot
	logic [ADDR_W-1:0] pend_addr;
	logic [WORD_W-1:0] pend_data;
	logic              wr_pend;
	logic              rd_req;
	logic              rd_done;    // data latched, host not yet released

	assign wr_pend = wr_req | pend_valid;
	assign rd_req  = ~csx & ~rdx;

	// ----------------------------------------
	// pending capture write
	// ----------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			pend_valid <= 1'b0;
		else if (wr_req)
			pend_valid <= 1'b1;
		else if (state == ARB_WRITE)
			pend_valid <= 1'b0; // issued

	always_ff @(posedge clk_llc)
		if (wr_req)
		begin
			pend_addr <= wr_addr;
			pend_data <= wr_data;
		end

	// ----------------------------------------
	// port FSM
	// ----------------------------------------
	always_comb
	begin
		state_nx = state;
		case (state)
			ARB_IDLE:
				if (wr_pend)
					state_nx = ARB_WRITE; // capture first
				else if (rd_req)
					state_nx = ARB_READ;
			ARB_WRITE:
				if (rd_done && rd_req)
					state_nx = ARB_HOLD; // back to a host read still open
				else
					state_nx = ARB_IDLE;
			ARB_READ:
				state_nx = ARB_HOLD;
			ARB_HOLD:
				if (wr_pend)
					state_nx = ARB_WRITE; // port is free while holding
				else if (!rd_req)
					state_nx = ARB_IDLE;
			default:
				state_nx = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			state <= ARB_IDLE;
		else
			state <= state_nx;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			rd_done <= 1'b0;
		else if (state == ARB_READ)
			rd_done <= 1'b1;
		else if (!rd_req)
			rd_done <= 1'b0; // host raised the strobes

	// ram answer for the address given in idle
	always_ff @(posedge clk_llc)
		if (state == ARB_READ)
			data <= ram_rdata;

	assign waitx = ~rd_req | rd_done; // low only while a read is owed

	// host address sits on the port except during a write
	assign ram_we    = (state == ARB_WRITE);
	assign ram_addr  = ram_we ? pend_addr : {read_bank, adr};
	assign ram_wdata = pend_data;

endmodule

// File: hdl/frame_ram.sv
`timescale 1ns/1ps

module frame_ram (
	input  logic                          clk_llc,
	input  logic [vision_pkg::ADDR_W-1:0] addr,
	input  logic [vision_pkg::WORD_W-1:0] wdata,
	input  logic                          we,
	output logic [vision_pkg::WORD_W-1:0] rdata
);
	import vision_pkg::*;

	// two banks of gray words
	logic [WORD_W-1:0] mem [0:(1 << ADDR_W)-1];

	// single port, read is registered
	always_ff @(posedge clk_llc)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr]; // old word on a write cycle
	end

endmodule

// File: hdl/vision_top.sv
`timescale 1ns/1ps

module vision_top (
	input  logic                               clk_llc,
	input  logic                               resetx,
	input  logic                               vref,
	input  logic                               href,
	input  logic                               odd,
	input  logic [vision_pkg::BYTE_W-1:0]      vpo,
	input  logic                               csx,
	input  logic                               rdx,
	input  logic [vision_pkg::HOST_ADDR_W-1:0] adr,
	output logic [vision_pkg::WORD_W-1:0]      data,
	output logic                               waitx,
	output logic                               irq0,
	output logic                               irq1
);
	import vision_pkg::*;

	// capture path
	logic               keep_byte;
	logic [PHASE_W-1:0] phase;
	logic               pix_valid;
	logic [WORD_W-1:0]  pix_word;
	logic [ADDR_W-1:0]  pix_addr;
	logic               read_bank;

	// memory port
	logic [ADDR_W-1:0]  ram_addr;
	logic [WORD_W-1:0]  ram_wdata;
	logic               ram_we;
	logic [WORD_W-1:0]  ram_rdata;

	field_sync u_sync (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.vref      (vref),
		.href      (href),
		.odd       (odd),
		.keep_byte (keep_byte),
		.phase     (phase),
		.pix_valid (pix_valid),
		.pix_addr  (pix_addr),
		.read_bank (read_bank),
		.irq0      (irq0),
		.irq1      (irq1)
	);

	ycbcr_to_gray u_conv (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.vpo       (vpo),
		.keep_byte (keep_byte),
		.phase     (phase),
		.pix_valid (pix_valid),
		.pix_word  (pix_word)
	);

	// capture writes and host reads share one port
	frame_arbiter u_arb (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.wr_req    (pix_valid),
		.wr_addr   (pix_addr),
		.wr_data   (pix_word),
		.read_bank (read_bank),
		.csx       (csx),
		.rdx       (rdx),
		.adr       (adr),
		.data      (data),
		.waitx     (waitx),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.ram_rdata (ram_rdata)
	);

	frame_ram u_ram (
		.clk_llc (clk_llc),
		.addr    (ram_addr),
		.wdata   (ram_wdata),
		.we      (ram_we),
		.rdata   (ram_rdata)
	);

endmodule

// File: bench/vision_assert.sv
`timescale 1ns/1ps

module vision_assert (
	input logic                   clk_llc,
	input logic                   resetx,
	input logic                   wr_req,
	input logic                   ram_we,
	input logic                   waitx,
	input vision_pkg::arb_state_t state
);
	import vision_pkg::*;

	int fail_cnt; // read by the bench at the end

	initial
		fail_cnt = 0;

	// ram cycle that fetches the host word carries no write
	no_write_in_read: assert property (@(posedge clk_llc) disable iff (!resetx)
		state == ARB_READ |-> $past(!ram_we))
	else
	begin
		$error("ram write in the cycle that fetched a host read");
		fail_cnt++;
	end

	// wait released only once the host data is latched
	wait_rise_in_hold: assert property (@(posedge clk_llc) disable iff (!resetx)
		$rose(waitx) |-> state == ARB_HOLD)
	else
	begin
		$error("waitx rose in arbiter state %0d", state);
		fail_cnt++;
	end

	// capture write reaches the ram within two cycles
	write_issued: assert property (@(posedge clk_llc) disable iff (!resetx)
		($past(wr_req) && !ram_we) |=> ram_we)
	else
	begin
		$error("pending capture write not issued within two cycles");
		fail_cnt++;
	end

endmodule

bind frame_arbiter vision_assert u_assert (
	.clk_llc (clk_llc),
	.resetx  (resetx),
	.wr_req  (wr_req),
	.ram_we  (ram_we),
	.waitx   (waitx),
	.state   (state)
);

// File: include/tb_vision_model.svh
`ifndef TB_VISION_MODEL_SVH
`define TB_VISION_MODEL_SVH

// clip of one sum to six bits, same range checks as the pipeline
function automatic int model_clip(input int s);
	if (s < 0)
		return 0;
	else if (s >= (1 << (vision_pkg::PROD_W - 3)))
		return (1 << vision_pkg::G_W) - 1; // full scale
	else
		return (s >> (vision_pkg::PROD_W - 3 - vision_pkg::G_W)) & ((1 << vision_pkg::G_W) - 1);
endfunction

// expected stored word for one cb y cr triple
function automatic logic [vision_pkg::WORD_W-1:0] model_gray(input logic [7:0] y,
	input logic [7:0] cb, input logic [7:0] cr);
	int yd, cbd, crd;
	int r6, g6, b6;
	int g;
	logic [vision_pkg::RB_W-1:0] g5;
	yd  = int'(y) * 4 - int'(vision_pkg::Y_OFFSET);
	cbd = int'(cb) * 4 - int'(vision_pkg::C_OFFSET);
	crd = int'(cr) * 4 - int'(vision_pkg::C_OFFSET);
	r6  = model_clip(int'(vision_pkg::K_Y) * yd + int'(vision_pkg::K_CR_R) * crd);
	g6  = model_clip(int'(vision_pkg::K_Y) * yd - int'(vision_pkg::K_CR_G) * crd
		- int'(vision_pkg::K_CB_G) * cbd);
	b6  = model_clip(int'(vision_pkg::K_Y) * yd + int'(vision_pkg::K_CB_B) * cbd);
	g   = (r6 >> 3) + (g6 >> 2) + (b6 >> 4); // r/4 + g/4 + b/8 on 5 bit r, b
	g5  = g[vision_pkg::RB_W-1:0];
	return {g5, g5, 1'b0, g5};
endfunction

// every other line of a field, first one kept
function automatic bit model_line_kept(input int line);
	return (line % 2) == 0;
endfunction

// only cb, y, cr of each group reach memory
function automatic bit model_byte_used(input int col);
	return (col % vision_pkg::GROUP_BYTES) <= int'(vision_pkg::PH_CR);
endfunction

// stored pixel number for a byte of a kept line
function automatic int model_pix_index(input int line, input int col, input int line_bytes);
	return (line / 2) * (line_bytes / vision_pkg::GROUP_BYTES) + col / vision_pkg::GROUP_BYTES;
endfunction

// memory word address, bank on top
function automatic logic [vision_pkg::ADDR_W-1:0] model_addr(input bit bank, input int idx);
	return {bank, idx[vision_pkg::HOST_ADDR_W-1:0]};
endfunction

`endif

// File: bench/tb_vision.sv
`timescale 1ns/1ps

module tb_vision;
	import vision_pkg::*;

	`include "tb_vision_model.svh"

	localparam logic [31:0] SEED = 32'hd08a_10e1;
	localparam int LINE_BYTES = 64;
	localparam int LINES      = 4;
	localparam int PIX        = (LINES / 2) * (LINE_BYTES / GROUP_BYTES); // 16 per field
	localparam int HBLANK     = 8;  // href low between lines
	localparam int VPRE       = 6;  // vref high before first line
	localparam int VPOST      = 16; // vref high after last line
	localparam int VGAP       = 16; // vref low after the field
	localparam int FIELD_CYC  = VPRE + LINES * (LINE_BYTES + HBLANK) + VPOST + VGAP;
	localparam int N_FIELDS   = 6;
	localparam int READ_CYC   = 8;  // worst host read incl. idle cycle
	localparam int N_READS    = 5 * PIX + FIELD_CYC / 3;
	localparam int MAX_CYCLES = 2 * (N_FIELDS * FIELD_CYC + N_READS * READ_CYC + 8);

	logic                   clk_llc;
	logic                   resetx;
	logic                   vref, href, odd;
	logic [BYTE_W-1:0]      vpo;
	logic                   csx, rdx;
	logic [HOST_ADDR_W-1:0] adr;
	logic [WORD_W-1:0]      data;
	logic                   waitx, irq0, irq1;

	logic [BYTE_W-1:0] vb [LINES][LINE_BYTES]; // bytes of the last field
	logic [WORD_W-1:0] exp_mem [2][PIX];       // model content of both banks
	bit                cur_bank;                // bank the dut writes next
	bit                in_field;                // active lines running
	int                errors, checks, tests_run, tests_failed, test_err0;
	int                irq0_hi, irq1_hi, irq0_rise, irq1_rise;
	logic              irq0_q, irq1_q;
	int                cycles;

	initial
		clk_llc = 1'b0;
	always #2 clk_llc = ~clk_llc;

	vision_top u_dut (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.vref    (vref),
		.href    (href),
		.odd     (odd),
		.vpo     (vpo),
		.csx     (csx),
		.rdx     (rdx),
		.adr     (adr),
		.data    (data),
		.waitx   (waitx),
		.irq0    (irq0),
		.irq1    (irq1)
	);

	// irq pulse monitor, sampled away from the active edge
	always @(negedge clk_llc)
	begin
		if (irq0)
			irq0_hi++;
		if (irq1)
			irq1_hi++;
		if (irq0 && !irq0_q)
			irq0_rise++;
		if (irq1 && !irq1_q)
			irq1_rise++;
		irq0_q = irq0;
		irq1_q = irq1;
	end

	// ----------------------------------------
	// checking helpers
	// ----------------------------------------
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("[FAIL] %s: got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic clear_irq_counts();
		irq0_hi   = 0;
		irq1_hi   = 0;
		irq0_rise = 0;
		irq1_rise = 0;
	endtask

	task automatic start_test();
		test_err0 = errors;
		clear_irq_counts();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_err0)
		begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - test_err0);
		end
		else
			$display("test %0d %s: ok", tests_run, name);
	endtask

	task automatic check_irq(input int hi0, input int hi1);
		compare_value("irq0 high cycles", irq0_hi, hi0);
		compare_value("irq0 pulses", irq0_rise, (hi0 > 0) ? 1 : 0);
		compare_value("irq1 high cycles", irq1_hi, hi1);
		compare_value("irq1 pulses", irq1_rise, (hi1 > 0) ? 1 : 0);
	endtask

	// ----------------------------------------
	// video source and model
	// ----------------------------------------
	task automatic build_expected(input bit bank);
		int ln;
		int col;
		for (ln = 0; ln < LINES; ln++)
			if (model_line_kept(ln))
				for (col = 0; col < LINE_BYTES; col += GROUP_BYTES)
					exp_mem[bank][model_pix_index(ln, col, LINE_BYTES)] =
						model_gray(vb[ln][col + 1], vb[ln][col], vb[ln][col + 2]);
	endtask

	// mode 0 random, 1 keep stored bytes of last field, 2 clip extremes
	task automatic run_field(input bit is_odd, input int mode);
		int ln;
		int col;
		for (ln = 0; ln < LINES; ln++)
			for (col = 0; col < LINE_BYTES; col++)
				if (!(mode == 1 && model_line_kept(ln) && model_byte_used(col)))
					vb[ln][col] = BYTE_W'($urandom);
		if (mode == 2)
			for (ln = 0; ln < LINES; ln++)
				for (col = 0; col < LINE_BYTES && model_line_kept(ln); col += GROUP_BYTES)
					if ((col / GROUP_BYTES) % 2 == 0)
					begin
						vb[ln][col + 1] = 8'hff; // y, r over full scale
						vb[ln][col + 2] = 8'hff; // cr
					end
					else
					begin
						vb[ln][col]     = 8'h00; // cb, b below zero
						vb[ln][col + 1] = 8'h00; // y
					end
		if (is_odd)
			cur_bank = ~cur_bank;
		odd  = is_odd;
		vref = 1'b1;
		repeat (VPRE) @(negedge clk_llc);
		in_field = is_odd;
		for (ln = 0; ln < LINES; ln++)
		begin
			for (col = 0; col < LINE_BYTES; col++)
			begin
				href = 1'b1;
				vpo  = vb[ln][col];
				@(negedge clk_llc);
			end
			href = 1'b0;
			repeat (HBLANK)
			begin
				vpo = BYTE_W'($urandom); // blanking noise
				@(negedge clk_llc);
			end
		end
		in_field = 1'b0;
		repeat (VPOST) @(negedge clk_llc);
		vref = 1'b0;
		odd  = 1'b0;
		repeat (VGAP) @(negedge clk_llc); // irq pulse falls in here
		if (is_odd)
			build_expected(cur_bank);
	endtask

	// ----------------------------------------
	// host strobe bus
	// ----------------------------------------
	task automatic host_read(input int a, output logic [WORD_W-1:0] d);
		adr = HOST_ADDR_W'(a);
		csx = 1'b0;
		rdx = 1'b0;
		@(negedge clk_llc);
		while (!waitx)
			@(negedge clk_llc);
		d   = data;
		csx = 1'b1;
		rdx = 1'b1;
		@(negedge clk_llc); // both high one cycle
	endtask

	task automatic read_words(input bit bank);
		logic [WORD_W-1:0] d;
		int                i;
		for (i = 0; i < PIX; i++)
		begin
			host_read(i, d);
			compare_value($sformatf("data bank %0d word %0d", bank, i), d, exp_mem[bank][i]);
		end
	endtask

	// direct look at the ram, for the bank the host cannot reach
	task automatic peek_bank(input bit bank);
		int i;
		for (i = 0; i < PIX; i++)
			compare_value($sformatf("mem bank %0d word %0d", bank, i),
				u_dut.u_ram.mem[model_addr(bank, i)], exp_mem[bank][i]);
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial
	begin
		int                nreads;
		bit                rbank;
		logic [WORD_W-1:0] rd;
		void'($urandom(SEED));
		resetx = 1'b0;
		vref   = 1'b0;
		href   = 1'b0;
		odd    = 1'b0;
		vpo    = '0;
		csx    = 1'b1;
		rdx    = 1'b1;
		adr    = '0;
		cur_bank = 1'b1; // first odd field goes to bank 0
		in_field = 1'b0;
		irq0_q   = 1'b0;
		irq1_q   = 1'b0;
		errors   = 0;
		checks   = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (4) @(negedge clk_llc);
		resetx = 1'b1;
		@(negedge clk_llc);

		start_test();
		compare_value("irq0", irq0, 0);
		compare_value("irq1", irq1, 0);
		compare_value("waitx", waitx, 1);
		finish_test("after reset");

		start_test();
		run_field(1'b1, 0);
		check_irq(2, 0);
		read_words(1'b0);
		finish_test("odd field into bank 0");

		start_test();
		run_field(1'b1, 0);
		check_irq(0, 2);
		read_words(1'b1);
		peek_bank(1'b0); // untouched by the second field
		finish_test("bank alternation");

		start_test();
		run_field(1'b1, 1); // dropped bytes and lines new, same stored words
		check_irq(2, 0);
		read_words(1'b0);
		clear_irq_counts();
		run_field(1'b0, 0); // even field
		check_irq(0, 0);
		peek_bank(1'b0);
		peek_bank(1'b1);
		finish_test("decimation");

		start_test();
		nreads = 0;
		rbank  = cur_bank; // bank not written by the coming field
		fork
			run_field(1'b1, 0);
			begin
				while (!in_field)
					@(negedge clk_llc);
				while (in_field)
				begin
					host_read(nreads % PIX, rd);
					compare_value($sformatf("data bank %0d word %0d during capture", rbank,
						nreads % PIX), rd, exp_mem[rbank][nreads % PIX]);
					nreads++;
				end
			end
		join
		if (nreads < PIX)
		begin
			errors++;
			$display("only %0d host reads finished during the capturing field", nreads);
		end
		check_irq(0, 2);
		read_words(1'b1);
		peek_bank(1'b0);
		finish_test("back-pressure");

		start_test();
		run_field(1'b1, 2);
		check_irq(2, 0);
		read_words(1'b0);
		finish_test("clipping");

		errors += u_dut.u_arb.u_assert.fail_cnt;
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, errors, u_dut.u_arb.u_assert.fail_cnt);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// run limit from field and read lengths
	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk_llc);
			cycles++;
		end
		$display("timeout, run stopped after %0d cycles", cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: fpga_vision.f
+incdir+include
hdl/vision_pkg.sv
hdl/field_sync.sv
hdl/ycbcr_to_gray.sv
hdl/frame_arbiter.sv
hdl/frame_ram.sv
hdl/vision_top.sv
bench/vision_assert.sv
bench/tb_vision.sv

// File: run_sim.sh
#!/bin/sh
# build the capture front end testbench with Verilator, run it, grep the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vision -Mdir obj_dir -f fpga_vision.f

# assertion errors are counted by the bench instead of stopping the run
./obj_dir/Vtb_vision +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log
then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
